// File: verilog/regAluPkg.sv
`default_nettype none

package regAluPkg;

        // Widths
        localparam int dataWidth     = 16;
        localparam int regIndexWidth = 4;
        localparam int busAddrWidth  = 8;
        localparam int busDataWidth  = 32;
        localparam int numRegs       = 16;

        typedef logic [dataWidth-1:0]     dataWord_t;
        typedef logic [regIndexWidth-1:0] regIndex_t;
        typedef logic [busAddrWidth-1:0]  busAddr_t;
        typedef logic [busDataWidth-1:0]  busWord_t;

        typedef enum logic [2:0] {
                opAdd,
                opSub,
                opAnd,
                opOr,
                opXor,
                opShl,
                opShr,
                opSltu
        } aluOp_t;

        ////////////////////////////////////////
        // Address map and command fields
        ////////////////////////////////////////
        localparam busAddr_t regWindowTop = 8'h3C;
        localparam busAddr_t cmdAddr      = 8'h40;

        localparam int cmdDestLsb = 0;
        localparam int cmdSrc1Lsb = 4;
        localparam int cmdSrc2Lsb = 8;
        localparam int cmdOpLsb   = 12;

        localparam logic [1:0] respOkay   = 2'b00;
        localparam logic [1:0] respSlvErr = 2'b10;

        // Host side of the bus
        typedef struct packed {
                logic     awvalid;
                busAddr_t awaddr;
                logic     wvalid;
                busWord_t wdata;
                logic     bready;
                logic     arvalid;
                busAddr_t araddr;
                logic     rready;
        } axiReq_t;

        // Slave side of the bus
        typedef struct packed {
                logic       awready;
                logic       wready;
                logic       bvalid;
                logic [1:0] bresp;
                logic       arready;
                logic       rvalid;
                busWord_t   rdata;
                logic [1:0] rresp;
        } axiRsp_t;

        typedef struct packed {
                regIndex_t readSelect1;
                regIndex_t readSelect2;
                regIndex_t writeSelect;
                logic      writeEnable;
                dataWord_t writeData;
        } regCtrl_t;

endpackage

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
        input  logic                clk,
        input  logic                rst,
        input  regAluPkg::regCtrl_t ctrl,
        output regAluPkg::dataWord_t readData1,
        output regAluPkg::dataWord_t readData2
);

        regAluPkg::dataWord_t regs [regAluPkg::numRegs];

        // One hot write enables
        logic [regAluPkg::numRegs-1:0] writeDecode;

        ////////////////////////////////////////
        // Write port
        ////////////////////////////////////////
        always_comb begin
                writeDecode = '0;
                if (ctrl.writeEnable) begin
                        writeDecode[ctrl.writeSelect] = 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < regAluPkg::numRegs; i++) begin
                                regs[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < regAluPkg::numRegs; i++) begin
                                if (writeDecode[i]) begin
                                        regs[i] <= ctrl.writeData;
                                end
                        end
                end
        end

        ////////////////////////////////////////
        // Read ports
        ////////////////////////////////////////

        // Old value is seen while the same register is written
        assign readData1 = regs[ctrl.readSelect1];
        assign readData2 = regs[ctrl.readSelect2];

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
        input  regAluPkg::aluOp_t    op,
        input  regAluPkg::dataWord_t operandA,
        input  regAluPkg::dataWord_t operandB,
        output regAluPkg::dataWord_t result
);

        // Shifts use the low four bits of B only
        logic [3:0] shiftAmount;

        assign shiftAmount = operandB[3:0];

        always_comb begin
                unique case (op)
                        regAluPkg::opAdd: begin
                                result = operandA + operandB;
                        end
                        regAluPkg::opSub: begin
                                result = operandA - operandB;
                        end
                        regAluPkg::opAnd: begin
                                result = operandA & operandB;
                        end
                        regAluPkg::opOr: begin
                                result = operandA | operandB;
                        end
                        regAluPkg::opXor: begin
                                result = operandA ^ operandB;
                        end
                        regAluPkg::opShl: begin
                                result = operandA << shiftAmount;
                        end
                        regAluPkg::opShr: begin
                                result = operandA >> shiftAmount;
                        end
                        regAluPkg::opSltu: begin
                                result = regAluPkg::dataWord_t'(operandA < operandB);
                        end
                        default: begin
                                result = '0;
                        end
                endcase
        end

endmodule

`default_nettype wire

// File: verilog/busRegisterBlock.sv
`timescale 1ns/1ps
`default_nettype none

module busRegisterBlock (
        input  logic                 clk,
        input  logic                 rst,
        input  regAluPkg::axiReq_t   req,
        output regAluPkg::axiRsp_t   rsp,
        output regAluPkg::regCtrl_t  ctrl,
        input  regAluPkg::dataWord_t readData1,
        input  regAluPkg::dataWord_t readData2,
        output regAluPkg::aluOp_t    aluOp,
        input  regAluPkg::dataWord_t aluResult
);

        typedef enum logic [1:0] {
                stIdle,
                stWriteResp,
                stReadResp
        } busState_t;

        busState_t state;
        busState_t nextState;

        logic writeOffered;
        logic writeAccept;
        logic readAccept;
        logic awIsReg;
        logic awIsCmd;
        logic arIsReg;
        logic arIsCmd;

        regAluPkg::regIndex_t awIndex;
        regAluPkg::regIndex_t arIndex;
        regAluPkg::busWord_t  cmdWord;
        regAluPkg::busWord_t  readValue;
        regAluPkg::busWord_t  rdataQ;
        logic [1:0]           brespQ;
        logic [1:0]           rrespQ;

        // Aligned address inside the register window
        function automatic logic inRegWindow(regAluPkg::busAddr_t addr);
                return (addr <= regAluPkg::regWindowTop) && (addr[1:0] == 2'b00);
        endfunction

        ////////////////////////////////////////
        // Address decode and handshake
        ////////////////////////////////////////
        assign awIsReg = inRegWindow(req.awaddr);
        assign awIsCmd = (req.awaddr == regAluPkg::cmdAddr);
        assign arIsReg = inRegWindow(req.araddr);
        assign arIsCmd = (req.araddr == regAluPkg::cmdAddr);
        assign awIndex = req.awaddr[2 +: regAluPkg::regIndexWidth];
        assign arIndex = req.araddr[2 +: regAluPkg::regIndexWidth];

        // Write wins over a read in the same cycle
        assign writeOffered = req.awvalid && req.wvalid;
        assign writeAccept  = (state == stIdle) && writeOffered;
        assign readAccept   = (state == stIdle) && !writeOffered && req.arvalid;

        // Register file steering
        always_comb begin
                ctrl.readSelect1 = arIndex;
                ctrl.readSelect2 = req.wdata[regAluPkg::cmdSrc2Lsb +: regAluPkg::regIndexWidth];
                ctrl.writeSelect = awIndex;
                ctrl.writeData   = req.wdata[regAluPkg::dataWidth-1:0];
                if (writeOffered && awIsCmd) begin
                        ctrl.readSelect1 = req.wdata[regAluPkg::cmdSrc1Lsb +: regAluPkg::regIndexWidth];
                        ctrl.writeSelect = req.wdata[regAluPkg::cmdDestLsb +: regAluPkg::regIndexWidth];
                        ctrl.writeData   = aluResult;
                end
                ctrl.writeEnable = writeAccept && (awIsReg || awIsCmd);
        end

        assign aluOp = regAluPkg::aluOp_t'(req.wdata[regAluPkg::cmdOpLsb +: 3]);

        always_comb begin
                if (arIsReg) begin
                        readValue = regAluPkg::busWord_t'(readData1);
                end else if (arIsCmd) begin
                        readValue = cmdWord;
                end else begin
                        readValue = '0;
                end
        end

        ////////////////////////////////////////
        // Transaction FSM
        ////////////////////////////////////////
        always_comb begin
                nextState = state;
                unique case (state)
                        stIdle: begin
                                if (writeAccept) begin
                                        nextState = stWriteResp;
                                end else if (readAccept) begin
                                        nextState = stReadResp;
                                end
                        end
                        stWriteResp: begin
                                if (req.bready) begin
                                        nextState = stIdle;
                                end
                        end
                        stReadResp: begin
                                if (req.rready) begin
                                        nextState = stIdle;
                                end
                        end
                        default: begin
                                nextState = stIdle;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state   <= stIdle;
                        cmdWord <= '0;
                end else begin
                        state <= nextState;
                        if (writeAccept && awIsCmd) begin
                                cmdWord <= req.wdata;
                        end
                end
        end

        // Response payload
        always_ff @(posedge clk) begin
                if (writeAccept) begin
                        brespQ <= (awIsReg || awIsCmd) ? regAluPkg::respOkay : regAluPkg::respSlvErr;
                end
                if (readAccept) begin
                        rdataQ <= readValue;
                        rrespQ <= (arIsReg || arIsCmd) ? regAluPkg::respOkay : regAluPkg::respSlvErr;
                end
        end

        assign rsp.awready = writeAccept;
        assign rsp.wready  = writeAccept;
        assign rsp.arready = readAccept;
        assign rsp.bvalid  = (state == stWriteResp);
        assign rsp.bresp   = brespQ;
        assign rsp.rvalid  = (state == stReadResp);
        assign rsp.rdata   = rdataQ;
        assign rsp.rresp   = rrespQ;

endmodule

`default_nettype wire

// File: verilog/regAluTop.sv
`timescale 1ns/1ps
`default_nettype none

module regAluTop (
        input  logic               clk,
        input  logic               rst,
        input  regAluPkg::axiReq_t req,
        output regAluPkg::axiRsp_t rsp
);

        regAluPkg::regCtrl_t  ctrl;
        regAluPkg::dataWord_t readData1;
        regAluPkg::dataWord_t readData2;
        regAluPkg::dataWord_t aluResult;
        regAluPkg::aluOp_t    aluOp;

        // Bus slave steers the datapath
        busRegisterBlock busBlock (
                .clk       (clk),
                .rst       (rst),
                .req       (req),
                .rsp       (rsp),
                .ctrl      (ctrl),
                .readData1 (readData1),
                .readData2 (readData2),
                .aluOp     (aluOp),
                .aluResult (aluResult)
        );

        registerFile regFile (
                .clk       (clk),
                .rst       (rst),
                .ctrl      (ctrl),
                .readData1 (readData1),
                .readData2 (readData2)
        );

        // Operands come straight off the read ports
        aluUnit alu (
                .op       (aluOp),
                .operandA (readData1),
                .operandB (readData2),
                .result   (aluResult)
        );

endmodule

`default_nettype wire

// File: verification/regAluTb_properties.sv
`timescale 1ns/1ps
`default_nettype none

module regAluTbProperties (
        input logic               clk,
        input logic               rst,
        input regAluPkg::axiReq_t req,
        input regAluPkg::axiRsp_t rsp
);

        ////////////////////////////////////////
        // Response channels hold until taken
        ////////////////////////////////////////
        bHold: assert property (@(posedge clk) disable iff (rst)
                rsp.bvalid && !req.bready |=> rsp.bvalid)
                else $error("bvalid dropped before bready");

        rHold: assert property (@(posedge clk) disable iff (rst)
                rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
                else $error("rvalid or rdata changed before rready");

        // One acceptance per cycle
        oneAccept: assert property (@(posedge clk) disable iff (rst)
                !(rsp.awready && rsp.arready))
                else $error("awready and arready high together");

        resetIdle: assert property (@(posedge clk)
                rst |=> !rsp.bvalid && !rsp.rvalid)
                else $error("response valid right after reset");

endmodule

bind regAluTop regAluTbProperties props (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
);

`default_nettype wire

// File: verification/regAluTb.sv
`timescale 1ns/1ps
`default_nettype none

module regAluTb;

        localparam int clkHalf       = 50;
        localparam int settle        = 10;
        localparam int timeoutCycles = 20;
        localparam int numCommands   = 32;

        logic clk;
        logic rst;
        regAluPkg::axiReq_t req;
        regAluPkg::axiRsp_t rsp;

        integer seed;
        logic [31:0] rnd;
        logic [31:0] lastCmd;
        logic [31:0] cmd;
        regAluPkg::dataWord_t shadow [regAluPkg::numRegs];
        regAluPkg::regIndex_t dest;
        regAluPkg::regIndex_t src1;
        regAluPkg::regIndex_t src2;
        regAluPkg::aluOp_t op;
        int stall;
        int drainCount;

        // Read responses waiting for the checker
        regAluPkg::busWord_t gotDataQ [$];
        logic [1:0]          gotRespQ [$];
        regAluPkg::busWord_t wantDataQ [$];
        logic [1:0]          wantRespQ [$];
        regAluPkg::busWord_t gotData;
        regAluPkg::busWord_t wantData;
        logic [1:0]          gotResp;
        logic [1:0]          wantResp;

        regAluTop u_dut (
                .clk (clk),
                .rst (rst),
                .req (req),
                .rsp (rsp)
        );

        always #(clkHalf) clk = ~clk;

        ////////////////////////////////////////
        // Reference model and helpers
        ////////////////////////////////////////
        function automatic regAluPkg::dataWord_t aluModel(input regAluPkg::aluOp_t aluOp,
                                                          input regAluPkg::dataWord_t a,
                                                          input regAluPkg::dataWord_t b);
                case (aluOp)
                        regAluPkg::opAdd:  return a + b;
                        regAluPkg::opSub:  return a - b;
                        regAluPkg::opAnd:  return a & b;
                        regAluPkg::opOr:   return a | b;
                        regAluPkg::opXor:  return a ^ b;
                        regAluPkg::opShl:  return a << b[3:0];
                        regAluPkg::opShr:  return a >> b[3:0];
                        regAluPkg::opSltu: return (a < b) ? 16'd1 : 16'd0;
                        default:           return 16'd0;
                endcase
        endfunction

        function automatic regAluPkg::busAddr_t regAddr(input int index);
                return regAluPkg::busAddr_t'(index * 4);
        endfunction

        task automatic reportMismatch(input string msg);
                $display("Fail at %0t ns: %s", $time, msg);
                $display("TEST FAILED");
                $fatal(1, "value mismatch");
        endtask

        task automatic reportTimeout(input string what);
                $display("Timed out after %0d cycles waiting for %s", timeoutCycles, what);
                $display("TEST FAILED");
                $fatal(1, "bus handshake stalled");
        endtask

        ////////////////////////////////////////
        // Bus tasks
        ////////////////////////////////////////

        // A stalled write also offers a read of the command register
        task automatic writeBus(input regAluPkg::busAddr_t addr, input regAluPkg::busWord_t data,
                                input logic [1:0] expResp, input int stallCycles);
                int count;
                logic [1:0] heldResp;
                @(negedge clk);
                req.awvalid = 1'b1;
                req.awaddr  = addr;
                req.wvalid  = 1'b1;
                req.wdata   = data;
                req.bready  = (stallCycles == 0);
                #(settle);
                count = 0;
                while (!(rsp.awready && rsp.wready)) begin
                        count++;
                        if (count > timeoutCycles) reportTimeout("awready and wready");
                        @(negedge clk);
                        #(settle);
                end
                @(negedge clk);
                req.awvalid = 1'b0;
                req.wvalid  = 1'b0;
                if (stallCycles > 0) begin
                        req.arvalid = 1'b1;
                        req.araddr  = regAluPkg::cmdAddr;
                end
                #(settle);
                count = 0;
                while (!rsp.bvalid) begin
                        count++;
                        if (count > timeoutCycles) reportTimeout("bvalid");
                        @(negedge clk);
                        #(settle);
                end
                assert (rsp.bresp == expResp)
                else reportMismatch($sformatf("bresp %0d, expected %0d", rsp.bresp, expResp));
                heldResp = rsp.bresp;
                for (int i = 0; i < stallCycles; i++) begin
                        @(negedge clk);
                        #(settle);
                        assert (rsp.bvalid && rsp.bresp == heldResp && !rsp.arready)
                        else reportMismatch("write response not held under back-pressure");
                end
                @(negedge clk);
                req.bready = 1'b1;
                #(settle);
                @(posedge clk);
        endtask

        // A stalled read keeps arvalid up as a second read of the same address
        task automatic readBus(input regAluPkg::busAddr_t addr, input regAluPkg::busWord_t expData,
                               input logic [1:0] expResp, input int stallCycles);
                int count;
                regAluPkg::busWord_t heldData;
                logic [1:0] heldResp;
                @(negedge clk);
                req.arvalid = 1'b1;
                req.araddr  = addr;
                req.rready  = (stallCycles == 0);
                #(settle);
                count = 0;
                while (!rsp.arready) begin
                        count++;
                        if (count > timeoutCycles) reportTimeout("arready");
                        @(negedge clk);
                        #(settle);
                end
                @(negedge clk);
                req.arvalid = (stallCycles > 0);
                #(settle);
                count = 0;
                while (!rsp.rvalid) begin
                        count++;
                        if (count > timeoutCycles) reportTimeout("rvalid");
                        @(negedge clk);
                        #(settle);
                end
                heldData = rsp.rdata;
                heldResp = rsp.rresp;
                gotDataQ.push_back(heldData);
                gotRespQ.push_back(heldResp);
                wantDataQ.push_back(expData);
                wantRespQ.push_back(expResp);
                for (int i = 0; i < stallCycles; i++) begin
                        @(negedge clk);
                        #(settle);
                        assert (rsp.rvalid && rsp.rdata == heldData && rsp.rresp == heldResp
                                && !rsp.arready)
                        else reportMismatch("read response not held under back-pressure");
                end
                @(negedge clk);
                req.rready = 1'b1;
                #(settle);
                @(posedge clk);
        endtask

        ////////////////////////////////////////
        // Checker
        ////////////////////////////////////////
        always @(posedge clk) begin
                if (gotDataQ.size() > 0) begin
                        gotData  = gotDataQ.pop_front();
                        gotResp  = gotRespQ.pop_front();
                        wantData = wantDataQ.pop_front();
                        wantResp = wantRespQ.pop_front();
                        assert (gotData == wantData)
                        else reportMismatch($sformatf("rdata %h, expected %h", gotData, wantData));
                        assert (gotResp == wantResp)
                        else reportMismatch($sformatf("rresp %0d, expected %0d", gotResp, wantResp));
                end
        end

        ////////////////////////////////////////
        // Stimulus
        ////////////////////////////////////////
        initial begin
                clk     = 1'b0;
                rst     = 1'b1;
                req     = '0;
                seed    = 32'h7613408f;
                lastCmd = '0;
                repeat (16) @(negedge clk);
                rst = 1'b0;

                // Everything clear after reset
                for (int i = 0; i < regAluPkg::numRegs; i++) begin
                        shadow[i] = '0;
                        readBus(regAddr(i), 32'h0, regAluPkg::respOkay, 0);
                end
                readBus(regAluPkg::cmdAddr, 32'h0, regAluPkg::respOkay, 0);

                // Direct writes drop the upper half of wdata
                for (int i = 0; i < regAluPkg::numRegs; i++) begin
                        rnd = $random(seed);
                        writeBus(regAddr(i), rnd, regAluPkg::respOkay, 0);
                        shadow[i] = rnd[15:0];
                end
                for (int i = 0; i < regAluPkg::numRegs; i++) begin
                        readBus(regAddr(i), {16'h0, shadow[i]}, regAluPkg::respOkay, 0);
                end

                // ALU commands with some dest equal to a source
                for (int n = 0; n < numCommands; n++) begin
                        rnd  = $random(seed);
                        op   = regAluPkg::aluOp_t'(n[2:0]);
                        src1 = rnd[7:4];
                        src2 = rnd[11:8];
                        dest = rnd[3:0];
                        if (n % 4 == 0) dest = src1;
                        if (n % 4 == 1) dest = src2;
                        cmd = {rnd[31:15], op, src2, src1, dest};
                        writeBus(regAluPkg::cmdAddr, cmd, regAluPkg::respOkay, 0);
                        shadow[dest] = aluModel(op, shadow[src1], shadow[src2]);
                        lastCmd = cmd;
                        readBus(regAddr(int'(dest)), {16'h0, shadow[dest]}, regAluPkg::respOkay, 0);
                end
                readBus(regAluPkg::cmdAddr, lastCmd, regAluPkg::respOkay, 0);

                // Back-pressure on both response channels
                rnd   = $random(seed);
                stall = 1 + int'(rnd[2:0]);
                writeBus(regAddr(3), rnd, regAluPkg::respOkay, stall);
                shadow[3] = rnd[15:0];
                readBus(regAluPkg::cmdAddr, lastCmd, regAluPkg::respOkay, 0);
                rnd   = $random(seed);
                stall = 1 + int'(rnd[2:0]);
                readBus(regAddr(3), {16'h0, shadow[3]}, regAluPkg::respOkay, stall);
                readBus(regAddr(3), {16'h0, shadow[3]}, regAluPkg::respOkay, 0);

                // Unmapped address and a sweep to confirm nothing moved
                rnd = $random(seed);
                writeBus(8'h80, rnd, regAluPkg::respSlvErr, 0);
                readBus(8'h80, 32'h0, regAluPkg::respSlvErr, 0);
                for (int i = 0; i < regAluPkg::numRegs; i++) begin
                        readBus(regAddr(i), {16'h0, shadow[i]}, regAluPkg::respOkay, 0);
                end

                drainCount = 0;
                while (gotDataQ.size() > 0 && drainCount < timeoutCycles) begin
                        @(negedge clk);
                        drainCount++;
                end
                if (gotDataQ.size() == 0) begin
                        $display("TEST PASSED");
                        $finish;
                end else begin
                        $display("Read responses were left unchecked");
                        $display("TEST FAILED");
                        $fatal(1, "checker did not drain");
                end
        end

endmodule

`default_nettype wire

// File: build.f
verilog/regAluPkg.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/busRegisterBlock.sv
verilog/regAluTop.sv
verification/regAluTb_properties.sv
verification/regAluTb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= regAluTb
FILELIST    ?= build.f
BUILD_DIR   ?= obj_dir
TIMESCALE   ?= 1ns/1ps
SIM_FLAGS   ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only --timing --assert
EXTRA_FLAGS ?=

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST) $(EXTRA_FLAGS)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) $(EXTRA_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
